// File: Bender.yml
package:
  name: cache_system

sources:
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/burst_pkg.sv
      - source/bram.sv
      - source/cache.sv
      - source/burst_ram.sv
      - source/cache_system.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/cache_system_properties.sv
      - bench/cache_system_tb.sv

// File: bench/cache_system_properties.sv
/* protocol checks bound into the cache
   word port handshake, burst command spacing and read burst framing */
`timescale 1ns/100ps
`include "cache_settings.svh"
`default_nettype none

module cache_system_properties
  import burst_pkg::*;
(
  input wire             clk,
  input wire             rst_n,
  input wire             enable,
  input wire [3:0]       write_enable,
  input wire             data_out_ready,
  input wire             busy,
  input wire burst_cmd_e br_cmd,
  input wire             br_cmd_en,
  input wire             br_rd_data_valid
);

  int unsigned failures = 0;

  // a reset cycle leaves both strobes low
  reset_idle: assert property (@(posedge clk)
    !rst_n |=> !br_cmd_en && !br_rd_data_valid)
    else begin
      failures++;
      $error("burst strobes not low after a reset cycle");
    end

  ready_only_on_read: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_ready |-> write_enable == 4'b0000)
    else begin
      failures++;
      $error("data_out_ready high during a write");
    end

  strobe_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en)
    else begin
      failures++;
      $error("br_cmd_en held longer than one cycle");
    end

  strobe_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en [*`COMMAND_INTERVAL_CYCLES])
    else begin
      failures++;
      $error("two burst commands closer than the command interval");
    end

  // first beat exactly at the read latency, then four beats back to back
  read_burst_framing: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en && br_cmd == BURST_READ |->
      ##1 !br_rd_data_valid [*(`BURST_READ_LATENCY - 1)]
      ##1 br_rd_data_valid [*BEATS_PER_BURST]
      ##1 !br_rd_data_valid)
    else begin
      failures++;
      $error("read burst beats out of frame");
    end

  // covers the beats, the last column write and the tag write
  busy_during_fill: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en && br_cmd == BURST_READ |->
      busy [*(`BURST_READ_LATENCY + BEATS_PER_BURST + 2)])
    else begin
      failures++;
      $error("busy dropped before the line fill finished");
    end

endmodule

bind cache cache_system_properties properties0 (
  .clk             (clk),
  .rst_n           (rst_n),
  .enable          (enable),
  .write_enable    (write_enable),
  .data_out_ready  (data_out_ready),
  .busy            (busy),
  .br_cmd          (br_cmd),
  .br_cmd_en       (br_cmd_en),
  .br_rd_data_valid(br_rd_data_valid)
);

`default_nettype wire

// File: bench/cache_system_tb.sv
/* testbench for the cache system
   LFSR driven word accesses checked against a shadow memory */
`timescale 1ns/100ps
`include "cache_settings.svh"
`default_nettype none

module cache_system_tb
  import cache_pkg::*;
();

  localparam int unsigned CLK_PERIOD = 100;
  localparam int unsigned RESET_CYCLES = 16;
  localparam logic [15:0] LFSR_SEED = 16'd54854;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;
  localparam int unsigned WORD_COUNT = 2 ** (`RAM_ADDRESS_BITS - 2);
  localparam int unsigned CACHE_WORDS = LINE_COUNT * COLUMN_COUNT;
  localparam int unsigned MIX_WORDS = 4 * CACHE_WORDS;
  localparam int unsigned HIT_ROUNDS = 32;
  localparam int unsigned MIX_ACCESSES = 200;
  localparam int unsigned ACCESS_COUNT =
    LINE_COUNT + 2 * HIT_ROUNDS + 4 * LINE_COUNT + MIX_ACCESSES;
  // write burst, interval, read burst, interval, plus handshake slack
  localparam int unsigned DIRTY_MISS_CYCLES =
    2 * (`COMMAND_INTERVAL_CYCLES + 1) + `BURST_READ_LATENCY + 16;
  localparam int unsigned TIMEOUT_CYCLES =
    RESET_CYCLES + 2 * LINE_COUNT + ACCESS_COUNT * DIRTY_MISS_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        enable;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [3:0]  write_enable;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;

  logic [31:0] shadow [WORD_COUNT];
  logic [15:0] lfsr_state;
  bit          access_missed;
  string       test_name;

  cache_system dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable        (enable),
    .address       (address),
    .data_in       (data_in),
    .write_enable  (write_enable),
    .data_out      (data_out),
    .data_out_ready(data_out_ready),
    .busy          (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return state[0] ? (state >> 1) ^ LFSR_TAPS : state >> 1;
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int unsigned count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic logic [3:0] random_lanes();
    logic [3:0] lanes;
    lanes = 4'(random_bits(4));
    // an all zero mask would turn the write into a read
    if (lanes == 4'b0000) begin
      lanes = 4'b1111;
    end
    return lanes;
  endfunction

  // called on a falling edge, returns on the falling edge where busy is low
  task automatic wait_ready();
    @(negedge clk);
    access_missed = busy;
    while (busy) begin
      @(negedge clk);
    end
  endtask

  task automatic write_word(input int unsigned word, input logic [31:0] data,
                            input logic [3:0] lanes);
    enable = 1'b1;
    address = word * 4;
    data_in = data;
    write_enable = lanes;
    wait_ready();
    // the lanes land at the next rising edge
    for (int b = 0; b < 4; b++) begin
      if (lanes[b]) begin
        shadow[word][8*b +: 8] = data[8*b +: 8];
      end
    end
    @(negedge clk);
  endtask

  task automatic read_word(input int unsigned word);
    logic [31:0] expected;
    expected = shadow[word];
    enable = 1'b1;
    address = word * 4;
    data_in = '0;
    write_enable = 4'b0000;
    wait_ready();
    assert (data_out_ready)
      else end_with_failure("read ended with busy low but data_out_ready low");
    assert (data_out == expected)
      else end_with_failure($sformatf("** Error [%s] word %0d: expected %h, actual %h",
                                      test_name, word, expected, data_out));
    @(negedge clk);
  endtask

  always @(negedge clk) begin
    if (dut0.cache0.properties0.failures != 0) begin
      end_with_failure("a protocol assertion on the cache failed");
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    end_with_failure("watchdog expired, an access never finished");
  end

  initial begin
    int unsigned word;
    logic [31:0] data;
    logic [3:0]  lanes;
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    data_in = '0;
    write_enable = 4'b0000;
    lfsr_state = LFSR_SEED;
    test_name = "reset";
    for (int i = 0; i < WORD_COUNT; i++) begin
      shadow[i] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // tag sweep holds busy high
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
    assert (!dut0.br_cmd_en && !dut0.br_rd_data_valid)
      else end_with_failure("burst port not idle after reset");

    test_name = "cold_read";
    for (int l = 0; l < LINE_COUNT; l++) begin
      read_word(l * COLUMN_COUNT + l % COLUMN_COUNT);
      assert (access_missed) else end_with_failure("first read of a line did not miss");
    end

    test_name = "write_hit";
    for (int n = 0; n < HIT_ROUNDS; n++) begin
      word = random_bits($clog2(CACHE_WORDS));
      data = random_bits(32);
      lanes = random_lanes();
      write_word(word, data, lanes);
      assert (!access_missed) else end_with_failure("write to a cached line missed");
      read_word(word);
    end

    // dirty every line, then force write-back and refill through a second tag
    test_name = "eviction";
    for (int l = 0; l < LINE_COUNT; l++) begin
      data = random_bits(32);
      write_word(l * COLUMN_COUNT + l % COLUMN_COUNT, data, 4'b1111);
    end
    for (int l = 0; l < LINE_COUNT; l++) begin
      word = l * COLUMN_COUNT + l % COLUMN_COUNT;
      data = random_bits(32);
      lanes = random_lanes();
      write_word(word + 2 * CACHE_WORDS, data, lanes);
      assert (access_missed) else end_with_failure("write to a conflicting tag did not miss");
      read_word(word);
      read_word(word + 2 * CACHE_WORDS);
    end

    test_name = "random_mix";
    for (int n = 0; n < MIX_ACCESSES; n++) begin
      word = random_bits($clog2(MIX_WORDS));
      if (random_bits(1) == 1) begin
        data = random_bits(32);
        lanes = random_lanes();
        write_word(word, data, lanes);
      end else begin
        read_word(word);
      end
    end

    enable = 1'b0;
    repeat (2) @(negedge clk);
    if (dut0.cache0.properties0.failures == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      end_with_failure("a protocol assertion on the cache failed");
    end
  end

endmodule

`default_nettype wire

// File: cache_system.f
+incdir+source
source/cache_pkg.sv
source/burst_pkg.sv
source/bram.sv
source/cache.sv
source/burst_ram.sv
source/cache_system.sv
bench/cache_system_properties.sv
bench/cache_system_tb.sv

// File: source/bram.sv
/* block RAM with one entry per cache line
   registered read, byte lane writes, payload type chosen per instance */
`timescale 1ns/100ps
`default_nettype none

module bram
  import cache_pkg::*;
#(
  parameter type payload_t = logic [31:0]
) (
  input  wire           clk,
  input  wire     [3:0] write_enable,
  input  wire line_ix_t address,
  input  wire payload_t data_in,
  output payload_t      data_out
);

  localparam int unsigned WIDTH = $bits(payload_t);

  logic [WIDTH-1:0] mem [LINE_COUNT];
  logic [WIDTH-1:0] wr_bits;
  logic [WIDTH-1:0] rd_q;

  assign wr_bits = data_in;
  assign data_out = rd_q;

  // lane n covers payload bits 8n to 8n+7
  always_ff @(posedge clk) begin
    for (int i = 0; i < WIDTH; i++) begin
      if (write_enable[i / 8]) begin
        mem[address][i] <= wr_bits[i];
      end
    end
    rd_q <= mem[address];
  end

endmodule

`default_nettype wire

// File: source/burst_pkg.sv
/* burst RAM protocol
   command kinds and the 64-bit beat format */
`default_nettype none

package burst_pkg;

  // one cache line moves as this many beats
  localparam int unsigned BEATS_PER_BURST = 4;
  localparam int unsigned BEAT_BYTES = 8;

  typedef logic [63:0] beat_t;

  typedef enum logic {
    BURST_READ  = 1'b0,
    BURST_WRITE = 1'b1
  } burst_cmd_e;

endpackage

`default_nettype wire

// File: source/burst_ram.sv
/* behavioral burst RAM in place of a PSRAM controller
   command strobe, fixed read latency and four-beat bursts */
`timescale 1ns/100ps
`include "cache_settings.svh"
`default_nettype none

module burst_ram
  import burst_pkg::*;
(
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire burst_cmd_e             br_cmd,
  input  wire                         br_cmd_en,
  input  wire [`RAM_ADDRESS_BITS-1:0] br_addr,
  input  wire beat_t                  br_wr_data,
  output beat_t                       br_rd_data,
  output logic                        br_rd_data_valid
);

  localparam int unsigned BEAT_ADDR_BITS = `RAM_ADDRESS_BITS - $clog2(BEAT_BYTES);
  localparam int unsigned LATENCY = `BURST_READ_LATENCY;
  // beats are fetched one cycle ahead of their valid flag
  localparam int unsigned PIPE_LEN = LATENCY - 2 + BEATS_PER_BURST;

  beat_t mem [2 ** BEAT_ADDR_BITS] = '{default: '0};

  logic [BEAT_ADDR_BITS-1:0] cmd_beat_addr;
  logic [BEAT_ADDR_BITS-1:0] wr_ptr;
  logic [BEAT_ADDR_BITS-1:0] rd_ptr;
  logic [1:0]                wr_left;
  logic [PIPE_LEN-1:0]       rd_pipe;
  logic                      wr_start;
  logic                      rd_start;
  logic                      fetch;

  assign cmd_beat_addr = br_addr[`RAM_ADDRESS_BITS-1 -: BEAT_ADDR_BITS];
  assign wr_start = br_cmd_en && br_cmd == BURST_WRITE;
  assign rd_start = br_cmd_en && br_cmd == BURST_READ;
  assign fetch = |rd_pipe[LATENCY-2 +: BEATS_PER_BURST];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_left <= '0;
      rd_pipe <= '0;
      br_rd_data_valid <= 1'b0;
    end else begin
      // read strobe delay line
      rd_pipe <= {rd_pipe[PIPE_LEN-2:0], rd_start};
      br_rd_data_valid <= fetch;
      if (wr_start) begin
        wr_left <= 2'(BEATS_PER_BURST - 1);
      end else if (wr_left != '0) begin
        wr_left <= wr_left - 1'b1;
      end
    end
  end

  // beat 0 of a write arrives with the strobe
  always_ff @(posedge clk) begin
    if (wr_start) begin
      mem[cmd_beat_addr] <= br_wr_data;
      wr_ptr <= cmd_beat_addr + 1'b1;
    end else if (wr_left != '0) begin
      mem[wr_ptr] <= br_wr_data;
      wr_ptr <= wr_ptr + 1'b1;
    end
    if (rd_start) begin
      rd_ptr <= cmd_beat_addr;
    end else if (fetch) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
    if (fetch) begin
      br_rd_data <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: source/cache.sv
/* direct-mapped write-back cache for a burst RAM
   word port hits, dirty line eviction and line refill over four-beat bursts */
`timescale 1ns/100ps
`include "cache_settings.svh"
`default_nettype none

module cache
  import cache_pkg::*, burst_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          enable,
  input  wire  [31:0]                  address,
  input  wire  [31:0]                  data_in,
  input  wire  [3:0]                   write_enable,
  output logic [31:0]                  data_out,
  output logic                         data_out_ready,
  output logic                         busy,
  output burst_cmd_e                   br_cmd,
  output logic                         br_cmd_en,
  output logic [`RAM_ADDRESS_BITS-1:0] br_addr,
  output beat_t                        br_wr_data,
  input  wire beat_t                   br_rd_data,
  input  wire                          br_rd_data_valid
);

  localparam int unsigned COUNT_BITS = $clog2(`COMMAND_INTERVAL_CYCLES + 1);
  localparam int unsigned PAIR_BITS = $clog2(BEATS_PER_BURST);
  localparam logic [PAIR_BITS-1:0] LAST_PAIR = PAIR_BITS'(BEATS_PER_BURST - 1);

  typedef enum logic [2:0] {
    IDLE,
    WB_BEATS,
    WB_WAIT,
    FILL,
    FILL_END,
    TAG_WRITE
  } state_e;

  state_e                state;
  logic [COUNT_BITS-1:0] interval_cnt;
  logic [PAIR_BITS-1:0]  pair_ix;
  logic                  sweep_active;
  line_ix_t              sweep_ix;
  line_ix_t              ram_ix;
  line_ix_t              line_q;
  logic                  entry_stale;
  tag_entry_t            entry;
  tag_entry_t            tag_wr_entry;
  logic [3:0]            tag_we;
  logic [31:0]           col_q [COLUMN_COUNT];
  logic [31:0]           col_wr_data [COLUMN_COUNT];
  logic [3:0]            col_we [COLUMN_COUNT];
  logic                  fill_valid_q;
  logic [PAIR_BITS-1:0]  fill_pair_q;
  beat_t                 fill_beat_q;

  column_ix_t column_ix;
  line_ix_t   line_ix;
  tag_t       address_tag;
  logic       entry_current;
  logic       tag_match;
  logic       hit;
  logic       hit_write;
  logic       miss_start;
  logic       wb_start;
  logic       fill_start;
  logic [`RAM_ADDRESS_BITS-1:0] victim_addr;
  logic [`RAM_ADDRESS_BITS-1:0] fill_addr;

  assign column_ix = address[BYTE_OFFSET_BITS +: COLUMN_IX_BITS];
  assign line_ix = address[LINE_LSB +: `CACHE_LINE_INDEX_BITS];
  assign address_tag = address[TAG_LSB +: TAG_BITS];

  // RAM outputs belong to the line addressed one cycle earlier
  assign ram_ix = sweep_active ? sweep_ix : line_ix;
  assign entry_current = !entry_stale && line_q == line_ix;
  assign tag_match = entry.valid && entry.tag == address_tag;
  assign hit = entry_current && tag_match;
  assign hit_write = enable && hit && state == IDLE && write_enable != 4'b0000;

  assign miss_start = state == IDLE && enable && entry_current && !tag_match &&
                      interval_cnt == '0;
  assign wb_start = miss_start && entry.valid && entry.dirty;
  assign fill_start = (miss_start && !(entry.valid && entry.dirty)) ||
                      (state == WB_WAIT && interval_cnt == '0);

  assign victim_addr = {entry.tag, line_ix, {LINE_LSB{1'b0}}};
  assign fill_addr = {address_tag, line_ix, {LINE_LSB{1'b0}}};

  assign busy = sweep_active || state != IDLE || interval_cnt != '0 || (enable && !hit);
  assign data_out = col_q[column_ix];
  assign data_out_ready = enable && hit && write_enable == 4'b0000;

  // tag writes come from the reset sweep, the end of a fill or a write hit
  always_comb begin
    tag_we = 4'b0000;
    tag_wr_entry = '0;
    if (sweep_active) begin
      tag_we = 4'b1111;
    end else if (state == TAG_WRITE) begin
      tag_we = 4'b1111;
      tag_wr_entry = '{dirty: 1'b0, valid: 1'b1, tag: address_tag};
    end else if (hit_write) begin
      tag_we = 4'b1111;
      tag_wr_entry = '{dirty: 1'b1, valid: 1'b1, tag: address_tag};
    end
  end

  // a beat fills two columns, low half into the even one
  always_comb begin
    for (int i = 0; i < COLUMN_COUNT; i++) begin
      col_we[i] = 4'b0000;
      col_wr_data[i] = i[0] ? fill_beat_q[63:32] : fill_beat_q[31:0];
      if (fill_valid_q && fill_pair_q == PAIR_BITS'(i / 2)) begin
        col_we[i] = 4'b1111;
      end else if (hit_write && column_ix == COLUMN_IX_BITS'(i)) begin
        col_we[i] = write_enable;
        col_wr_data[i] = data_in;
      end
    end
  end

  bram #(
    .payload_t(tag_entry_t)
  ) tag_ram (
    .clk         (clk),
    .write_enable(tag_we),
    .address     (ram_ix),
    .data_in     (tag_wr_entry),
    .data_out    (entry)
  );

  for (genvar c = 0; c < COLUMN_COUNT; c++) begin : g_column
    bram #(
      .payload_t(logic [31:0])
    ) column_ram (
      .clk         (clk),
      .write_enable(col_we[c]),
      .address     (ram_ix),
      .data_in     (col_wr_data[c]),
      .data_out    (col_q[c])
    );
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      br_cmd_en <= 1'b0;
      interval_cnt <= '0;
      pair_ix <= '0;
      sweep_active <= 1'b1;
      sweep_ix <= '0;
      entry_stale <= 1'b1;
      fill_valid_q <= 1'b0;
      fill_pair_q <= '0;
    end else begin
      br_cmd_en <= 1'b0;
      fill_valid_q <= 1'b0;
      line_q <= ram_ix;
      // the read at a tag write edge still returns the old entry
      entry_stale <= tag_we != 4'b0000;
      if (interval_cnt != '0) begin
        interval_cnt <= interval_cnt - 1'b1;
      end
      if (sweep_active) begin
        sweep_ix <= sweep_ix + 1'b1;
        if (sweep_ix == line_ix_t'(LINE_COUNT - 1)) begin
          sweep_active <= 1'b0;
        end
      end
      if (wb_start || fill_start) begin
        br_cmd_en <= 1'b1;
        interval_cnt <= COUNT_BITS'(`COMMAND_INTERVAL_CYCLES);
      end
      case (state)
        IDLE: begin
          if (wb_start) begin
            pair_ix <= PAIR_BITS'(1);
            state <= WB_BEATS;
          end else if (fill_start) begin
            pair_ix <= '0;
            state <= FILL;
          end
        end
        WB_BEATS: begin
          pair_ix <= pair_ix + 1'b1;
          if (pair_ix == LAST_PAIR) begin
            state <= WB_WAIT;
          end
        end
        WB_WAIT: begin
          if (fill_start) begin
            state <= FILL;
          end
        end
        FILL: begin
          if (br_rd_data_valid) begin
            fill_valid_q <= 1'b1;
            fill_pair_q <= pair_ix;
            pair_ix <= pair_ix + 1'b1;
            if (pair_ix == LAST_PAIR) begin
              state <= FILL_END;
            end
          end
        end
        FILL_END: state <= TAG_WRITE;
        TAG_WRITE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // burst command and beat registers
  always_ff @(posedge clk) begin
    fill_beat_q <= br_rd_data;
    if (wb_start) begin
      br_cmd <= BURST_WRITE;
      br_addr <= victim_addr;
      br_wr_data <= {col_q[1], col_q[0]};
    end else if (state == WB_BEATS) begin
      br_wr_data <= {col_q[{pair_ix, 1'b1}], col_q[{pair_ix, 1'b0}]};
    end else if (fill_start) begin
      br_cmd <= BURST_READ;
      br_addr <= fill_addr;
    end
  end

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
/* cache organization
   address fields, tag entry layout and index types */
`include "cache_settings.svh"
`default_nettype none

package cache_pkg;

  localparam int unsigned BYTE_OFFSET_BITS = 2;
  localparam int unsigned COLUMN_IX_BITS = 3;
  localparam int unsigned COLUMN_COUNT = 2 ** COLUMN_IX_BITS;
  localparam int unsigned LINE_COUNT = 2 ** `CACHE_LINE_INDEX_BITS;

  // |tag|line|column|00| of the byte address
  localparam int unsigned LINE_LSB = COLUMN_IX_BITS + BYTE_OFFSET_BITS;
  localparam int unsigned TAG_LSB = LINE_LSB + `CACHE_LINE_INDEX_BITS;
  localparam int unsigned TAG_BITS = `RAM_ADDRESS_BITS - TAG_LSB;

  typedef logic [COLUMN_IX_BITS-1:0] column_ix_t;
  typedef logic [`CACHE_LINE_INDEX_BITS-1:0] line_ix_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  typedef struct packed {
    logic dirty;
    logic valid;
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

// File: source/cache_settings.svh
/* cache system sizes
   line count, burst RAM address width and burst timing */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// log2 of the number of cache lines
`define CACHE_LINE_INDEX_BITS 4

// byte address width of the burst RAM
`define RAM_ADDRESS_BITS 12

// minimum clock cycles between two burst commands
`define COMMAND_INTERVAL_CYCLES 13

// cycles from a read command to its first data beat
`define BURST_READ_LATENCY 6

`endif

// File: source/cache_system.sv
/* cache system top level
   word port cache joined to the behavioral burst RAM */
`timescale 1ns/100ps
`include "cache_settings.svh"
`default_nettype none

module cache_system
  import burst_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        enable,
  input  wire [31:0] address,
  input  wire [31:0] data_in,
  input  wire [3:0]  write_enable,
  output wire [31:0] data_out,
  output wire        data_out_ready,
  output wire        busy
);

  burst_cmd_e                   br_cmd;
  logic                         br_cmd_en;
  logic [`RAM_ADDRESS_BITS-1:0] br_addr;
  beat_t                        br_wr_data;
  beat_t                        br_rd_data;
  logic                         br_rd_data_valid;

  cache cache0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable          (enable),
    .address         (address),
    .data_in         (data_in),
    .write_enable    (write_enable),
    .data_out        (data_out),
    .data_out_ready  (data_out_ready),
    .busy            (busy),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  burst_ram burst_ram0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

endmodule

`default_nettype wire
